// ==== logic/lsu_consts.svh ====
// Width, lane count, memory depth and operation code width constants for the load and store unit.
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// ********************
// Data path
// ********************

// Data width of one register and one memory doubleword.
`define LSU_XLEN 64

// Byte lanes in one doubleword, one memory bank each.
`define LSU_LANES 8

// ********************
// Memory and operation
// ********************

// Doublewords held by each bank; address bits 10 down to 3 index it.
`define LSU_MEM_WORDS 256

`define LSU_OP_W 3

`endif

// ==== logic/lsu_pkg.sv ====
// Memory operation codes and byte lane mask and data types for the load and store unit.
`include "lsu_consts.svh"

package lsu_pkg;

  // Size and extension of an access, as decoded by the core.
  typedef enum logic [`LSU_OP_W-1:0] {
    MEM_LB   = 3'd0,
    MEM_LBU  = 3'd1,
    MEM_LH   = 3'd2,
    MEM_LHU  = 3'd3,
    MEM_LW   = 3'd4,
    MEM_LWU  = 3'd5,
    MEM_LD   = 3'd6,
    MEM_NONE = 3'd7
  } mem_op_e;

  // One write enable per byte lane.
  typedef logic [`LSU_LANES-1:0] lane_mask_t;

  // A doubleword split into its byte lanes, lane 0 at the lowest address.
  typedef logic [`LSU_LANES-1:0][7:0] lane_data_t;

endpackage

// ==== logic/lsu_store_align.sv ====
// Store aligner: byte write mask, lane-shifted store data, gated load strobe and misalignment flag.
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_store_align
  import lsu_pkg::*;
(
  input  logic [2:0]           i_addr,
  input  logic [`LSU_XLEN-1:0] i_wdata,
  input  mem_op_e              i_mem_op,
  input  logic                 i_wr_en,
  input  logic                 i_rd_en,
  output lane_mask_t           o_wmask,
  output lane_data_t           o_lane_data,
  output logic                 o_rd_go,
  output logic                 o_misaligned
);

  lane_mask_t size_mask;
  logic [2:0] align_chk;
  logic       op_valid;
  logic       aligned;
  logic [5:0] shamt;

  // ********************
  // Size decode
  // ********************

  // The low offset bits named by align_chk must be zero for an aligned access.
  always_comb begin
    size_mask = '0;
    align_chk = 3'b000;
    case (i_mem_op)
      MEM_LB, MEM_LBU: begin
        size_mask = 8'h01;
        align_chk = 3'b000;
      end
      MEM_LH, MEM_LHU: begin
        size_mask = 8'h03;
        align_chk = 3'b001;
      end
      MEM_LW, MEM_LWU: begin
        size_mask = 8'h0f;
        align_chk = 3'b011;
      end
      MEM_LD: begin
        size_mask = 8'hff;
        align_chk = 3'b111;
      end
      default: begin
        size_mask = '0;
        align_chk = 3'b000;
      end
    endcase
  end

  assign op_valid = (i_mem_op != MEM_NONE);
  assign aligned  = ((i_addr & align_chk) == 3'b000);
  assign shamt    = {i_addr, 3'b000};

  // ********************
  // Outputs
  // ********************

  // A misaligned store writes no lane at all.
  assign o_wmask = (i_wr_en && op_valid && aligned) ? lane_mask_t'(size_mask << i_addr) : '0;

  assign o_lane_data = i_wdata << shamt;

  // A store in the same cycle wins over the load.
  assign o_rd_go = i_rd_en && !i_wr_en && op_valid;

  assign o_misaligned = (i_wr_en || i_rd_en) && op_valid && !aligned;

endmodule

// ==== logic/lsu_byte_bank.sv ====
// One byte lane of data memory with masked write and registered read.
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_byte_bank #(
  parameter int DEPTH = `LSU_MEM_WORDS
) (
  input  logic                     i_clk,
  input  logic [$clog2(DEPTH)-1:0] i_index,
  input  logic                     i_we,
  input  logic [7:0]               i_wbyte,
  input  logic                     i_re,
  output logic [7:0]               o_rbyte
);

  logic [7:0] mem [DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_index] <= i_wbyte;
    end
  end

  // Read data holds between loads.
  always_ff @(posedge i_clk) begin
    if (i_re) begin
      o_rbyte <= mem[i_index];
    end
  end

endmodule

// ==== logic/lsu_load_extract.sv ====
// Load extractor: offset shift, zero or sign extension and the registered write-back result.
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_load_extract
  import lsu_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_rd_go,
  input  mem_op_e              i_mem_op,
  input  logic [2:0]           i_offset,
  input  lane_data_t           i_rdword,
  output logic [`LSU_XLEN-1:0] o_rf_wdata,
  output logic                 o_rf_valid
);

  logic                 rd_go_q;
  mem_op_e              op_q;
  logic [2:0]           off_q;
  logic [`LSU_XLEN-1:0] rdword_sh;
  logic [`LSU_XLEN-1:0] ext_data;

  // ********************
  // Request stage
  // ********************

  // These registers line up with the byte the banks capture on the same edge.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_go_q <= 1'b0;
    end else begin
      rd_go_q <= i_rd_go;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rd_go) begin
      op_q  <= i_mem_op;
      off_q <= i_offset;
    end
  end

  // ********************
  // Shift and extend
  // ********************

  assign rdword_sh = i_rdword >> {off_q, 3'b000};

  always_comb begin
    case (op_q)
      MEM_LB:  ext_data = {{56{rdword_sh[7]}}, rdword_sh[7:0]};
      MEM_LBU: ext_data = {56'd0, rdword_sh[7:0]};
      MEM_LH:  ext_data = {{48{rdword_sh[15]}}, rdword_sh[15:0]};
      MEM_LHU: ext_data = {48'd0, rdword_sh[15:0]};
      MEM_LW:  ext_data = {{32{rdword_sh[31]}}, rdword_sh[31:0]};
      MEM_LWU: ext_data = {32'd0, rdword_sh[31:0]};
      default: ext_data = rdword_sh;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rf_wdata <= '0;
      o_rf_valid <= 1'b0;
    end else begin
      o_rf_valid <= rd_go_q;
      if (rd_go_q) begin
        o_rf_wdata <= ext_data;
      end
    end
  end

endmodule

// ==== logic/lsu_top.sv ====
// Load and store unit top: store aligner, eight byte banks and the load extractor.
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic [`LSU_XLEN-1:0] i_addr,
  input  logic [`LSU_XLEN-1:0] i_wdata,
  input  mem_op_e              i_mem_op,
  input  logic                 i_wr_en,
  input  logic                 i_rd_en,
  output logic [`LSU_XLEN-1:0] o_rf_wdata,
  output logic                 o_rf_valid,
  output logic                 o_misaligned
);

  localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

  lane_mask_t wmask;
  lane_data_t lane_data;
  lane_data_t rdword;
  logic       rd_go;

  // ********************
  // Store alignment
  // ********************

  lsu_store_align u_align (
    .i_addr       (i_addr[2:0]),
    .i_wdata      (i_wdata),
    .i_mem_op     (i_mem_op),
    .i_wr_en      (i_wr_en),
    .i_rd_en      (i_rd_en),
    .o_wmask      (wmask),
    .o_lane_data  (lane_data),
    .o_rd_go      (rd_go),
    .o_misaligned (o_misaligned)
  );

  // ********************
  // Byte banks
  // ********************

  // Address bits above the bank index are not decoded.
  for (genvar n = 0; n < `LSU_LANES; n++) begin : g_lane
    lsu_byte_bank #(
      .DEPTH (`LSU_MEM_WORDS)
    ) u_bank (
      .i_clk   (i_clk),
      .i_index (i_addr[IDX_W+2:3]),
      .i_we    (wmask[n]),
      .i_wbyte (lane_data[n]),
      .i_re    (rd_go),
      .o_rbyte (rdword[n])
    );
  end

  // ********************
  // Load extraction
  // ********************

  lsu_load_extract u_extract (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rd_go    (rd_go),
    .i_mem_op   (i_mem_op),
    .i_offset   (i_addr[2:0]),
    .i_rdword   (rdword),
    .o_rf_wdata (o_rf_wdata),
    .o_rf_valid (o_rf_valid)
  );

endmodule

// ==== verif/tb_clock.sv ====
// Testbench clock generator with a configurable period.
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

endmodule

// ==== verif/lsu_assertions.sv ====
// Concurrent assertions on the load and store unit top level, and their bind to lsu_top.
`timescale 1ns/100ps

module lsu_assertions
  import lsu_pkg::*;
(
  input logic       i_clk,
  input logic       i_rst_n,
  input logic [2:0] i_addr,
  input mem_op_e    i_mem_op,
  input logic       i_wr_en,
  input logic       i_rd_en,
  input lane_mask_t i_wmask,
  input logic       i_rf_valid
);

  logic no_load;
  int   n_bytes;
  logic mis_store;

  // A request with both strobes or with no operation never starts a load.
  assign no_load = (i_wr_en && i_rd_en) || (i_mem_op == MEM_NONE);

  // Access size in bytes. No operation counts as one byte, so it is never misaligned.
  always_comb begin
    case (i_mem_op)
      MEM_LH, MEM_LHU: n_bytes = 2;
      MEM_LW, MEM_LWU: n_bytes = 4;
      MEM_LD:          n_bytes = 8;
      default:         n_bytes = 1;
    endcase
  end

  assign mis_store = i_wr_en && ((int'(i_addr) % n_bytes) != 0);

  // The result of a request appears two rising edges after it is sampled.
  a_no_pulse_for_dropped_load : assert property (
    @(posedge i_clk) disable iff (!i_rst_n) $past(no_load, 2) |-> !i_rf_valid
  ) else $error("load result pulse after a request that carries no load");

  a_misaligned_store_no_write : assert property (
    @(posedge i_clk) mis_store |-> (i_wmask == '0)
  ) else $error("misaligned store drives a nonzero write mask");

  a_no_valid_in_reset : assert property (
    @(posedge i_clk) !i_rst_n |-> !i_rf_valid
  ) else $error("load result valid while reset is asserted");

endmodule

bind lsu_top lsu_assertions u_lsu_assertions (
  .i_clk      (i_clk),
  .i_rst_n    (i_rst_n),
  .i_addr     (i_addr[2:0]),
  .i_mem_op   (i_mem_op),
  .i_wr_en    (i_wr_en),
  .i_rd_en    (i_rd_en),
  .i_wmask    (wmask),
  .i_rf_valid (o_rf_valid)
);

// ==== verif/lsu_tb.sv ====
// Load and store unit testbench: LFSR stimulus, byte memory model, result checks and timeout.
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_tb
  import lsu_pkg::*;
();

  localparam int RAND_CYCLES = 2000;
  // Reset, memory fill, 12 aligned rounds of 11, 8 misaligned rounds of 9, random run, drain.
  localparam int TOTAL_CYCLES = 11 + `LSU_MEM_WORDS + 12 * 11 + 8 * 9 + RAND_CYCLES + 4;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES + 100;

  logic                 clk;
  logic                 rst_n;
  logic [`LSU_XLEN-1:0] addr;
  logic [`LSU_XLEN-1:0] wdata;
  mem_op_e              mem_op;
  logic                 wr_en;
  logic                 rd_en;
  logic [`LSU_XLEN-1:0] rf_wdata;
  logic                 rf_valid;
  logic                 misaligned;

  logic [31:0] lfsr = 32'd91349;
  logic [7:0]  mem_model [int];
  logic [63:0] exp_data_q [$];
  int          exp_due_q [$];
  logic        exp_mis = 1'b0;
  logic [63:0] last_wdata = '0;
  int          ncyc = 0;
  int          cyc_total = 0;
  int          errors = 0;

  tb_clock #(.PERIOD_NS (100)) u_clock (.o_clk (clk));

  lsu_top dut0 (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_addr       (addr),
    .i_wdata      (wdata),
    .i_mem_op     (mem_op),
    .i_wr_en      (wr_en),
    .i_rd_en      (rd_en),
    .o_rf_wdata   (rf_wdata),
    .o_rf_valid   (rf_valid),
    .o_misaligned (misaligned)
  );

  // ********************
  // Reference model
  // ********************

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit returned.
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic int op_bytes(input mem_op_e op);
    return (op == MEM_NONE) ? 0 : (op == MEM_LD) ? 8 : 1 << (int'(op) / 2);
  endfunction

  // Bytes from the offset to the end of the doubleword, zero above, then extended.
  function automatic logic [63:0] load_value(input logic [63:0] a, input mem_op_e op);
    logic [63:0] dw;
    int          sh;
    dw = '0;
    for (int i = 0; i < 8 - int'(a[2:0]); i++) begin
      dw[8*i +: 8] = mem_model[int'(a[10:0]) + i];
    end
    sh = 64 - 8 * op_bytes(op);
    dw = dw << sh;
    if (op == MEM_LB || op == MEM_LH || op == MEM_LW) begin
      return $signed(dw) >>> sh;
    end
    return dw >> sh;
  endfunction

  // ********************
  // Checks and stimulus
  // ********************

  task automatic check_outputs();
    logic [63:0] exp;
    int          due;
    if (misaligned !== exp_mis) begin
      $display("[ERROR] %0t o_misaligned expected %b got %b", $time, exp_mis, misaligned);
      errors++;
    end
    if (rf_valid !== 1'b1) begin
      if (rf_wdata !== last_wdata) begin
        $display("[ERROR] %0t o_rf_wdata expected %h got %h", $time, last_wdata, rf_wdata);
        errors++;
      end
      if (exp_due_q.size() > 0 && exp_due_q[0] <= ncyc) begin
        due = exp_due_q.pop_front();
        exp = exp_data_q.pop_front();
        $display("Load result due in cycle %0d did not arrive", due);
        errors++;
      end
    end else if (exp_data_q.size() == 0) begin
      $display("Load result pulse at %0t with no load outstanding", $time);
      errors++;
    end else begin
      exp = exp_data_q.pop_front();
      due = exp_due_q.pop_front();
      if (due != ncyc) begin
        $display("Load result at %0t came in cycle %0d instead of %0d", $time, ncyc, due);
        errors++;
      end
      if (rf_wdata !== exp) begin
        $display("[ERROR] %0t o_rf_wdata expected %h got %h", $time, exp, rf_wdata);
        errors++;
      end
      last_wdata = rf_wdata;
    end
  endtask

  task automatic request(input logic wr, input logic rd, input mem_op_e op,
                         input logic [63:0] a, input logic [63:0] d);
    logic mis;
    @(negedge clk);
    ncyc++;
    check_outputs();
    mis     = (op_bytes(op) > 1) && (int'(a[2:0]) % op_bytes(op) != 0);
    addr    = a;
    wdata   = d;
    mem_op  = op;
    wr_en   = wr;
    rd_en   = rd;
    exp_mis = (wr || rd) && mis;
    if (wr && !mis && op != MEM_NONE) begin
      for (int i = 0; i < op_bytes(op); i++) begin
        mem_model[int'(a[10:0]) + i] = d[8*i +: 8];
      end
    end else if (rd && !wr && op != MEM_NONE) begin
      exp_data_q.push_back(load_value(a, op));
      exp_due_q.push_back(ncyc + 2);
    end
  endtask

  always @(posedge clk) begin
    cyc_total++;
    if (cyc_total >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    logic [63:0] r;
    logic [63:0] d;
    logic [63:0] a;
    logic [63:0] base;
    mem_op_e     op;
    rst_n  = 1'b0;
    addr   = '0;
    wdata  = '0;
    mem_op = MEM_NONE;
    wr_en  = 1'b0;
    rd_en  = 1'b0;
    a      = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Fill every doubleword so that no load returns undefined bytes.
    for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
      request(1'b1, 1'b0, MEM_LD, 64'(i) << 3, lfsr_bits(64));
    end

    // Stores of each size with the sign bits set in odd rounds, then every load operation.
    for (int it = 0; it < 12; it++) begin
      r    = lfsr_bits(16);
      base = r & ~64'h7;
      d    = lfsr_bits(64) | ((it % 2 == 1) ? 64'h8000_8080 : 64'd0);
      request(1'b1, 1'b0, MEM_LD, base, lfsr_bits(64));
      request(1'b1, 1'b0, MEM_LWU, base | 64'd4, d);
      request(1'b1, 1'b0, MEM_LH, base | 64'd2, d);
      request(1'b1, 1'b0, MEM_LBU, base | 64'd1, d);
      for (int k = 0; k < 7; k++) begin
        request(1'b0, 1'b1, mem_op_e'(k), base | ((k == 6) ? 64'd0 : 64'd1 << (k / 2)), d);
      end
    end

    // Misaligned accesses, no operation, and both strobes in one cycle.
    for (int it = 0; it < 8; it++) begin
      r    = lfsr_bits(16);
      base = r & ~64'h7;
      a    = base | (r & 64'h6) | 64'd1;
      d    = lfsr_bits(64);
      op   = mem_op_e'(2 + it % 5);
      request(1'b1, 1'b0, op, a, d);
      request(1'b0, 1'b1, MEM_LD, base, d);
      request(1'b0, 1'b1, op, a, d);
      request(1'b1, 1'b0, MEM_NONE, base, d);
      request(1'b0, 1'b1, MEM_NONE, base, d);
      request(1'b1, 1'b1, MEM_NONE, a, d);
      request(1'b0, 1'b1, MEM_LD, base, d);
      request(1'b1, 1'b1, MEM_LD, base, ~d);
      request(1'b0, 1'b1, MEM_LD, base, d);
    end

    // Random traffic. A quarter of the requests reuse the previous address.
    for (int i = 0; i < RAND_CYCLES; i++) begin
      r  = lfsr_bits(8);
      op = mem_op_e'(r[4:2]);
      if (r[6:5] != 2'b00) begin
        a = lfsr_bits(16);
      end
      if (r[7]) begin
        a[2:0] = a[2:0] & ~3'(op_bytes(op) - 1);
      end
      request(r[0], r[1], op, a, lfsr_bits(64));
    end

    repeat (4) begin
      request(1'b0, 1'b0, MEM_NONE, a, '0);
    end
    if (exp_data_q.size() != 0) begin
      $display("%0d load results never arrived", exp_data_q.size());
      errors++;
    end
    $display("Checks finished with %0d errors in %0d cycles", errors, ncyc);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_store_align.sv
logic/lsu_byte_bank.sv
logic/lsu_load_extract.sv
logic/lsu_top.sv
verif/tb_clock.sv
verif/lsu_assertions.sv
verif/lsu_tb.sv

// ==== Makefile ====
.PHONY: run clean

run: obj_dir/Vlsu_tb
	obj_dir/Vlsu_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Test OK$$" sim.log

obj_dir/Vlsu_tb: tb.f $(wildcard logic/*.sv logic/*.svh verif/*.sv)
	verilator --binary --assert -j 0 --top-module lsu_tb -f tb.f

clean:
	rm -rf obj_dir sim.log
